// File: qerv_core.f
+incdir+logic
logic/qerv_isa_pkg.sv
logic/qerv_bus_pkg.sv
logic/qerv_state.sv
logic/qerv_decode.sv
logic/qerv_rf.sv
logic/qerv_alu.sv
logic/qerv_mem_if.sv
logic/qerv_bus_arbiter.sv
logic/qerv_core.sv
bench/qerv_clk_gen.sv
bench/qerv_core_sva.sv
bench/qerv_core_tb.sv

// File: bench/qerv_core_tb.sv
`timescale 1ns/100ps

`include "qerv_defines.svh"

module qerv_core_tb;

   localparam int          TOTAL_INSNS  = 40;
   localparam int          RESET_CYCLES = 6 * 14;
   localparam int          CYCLE_LIMIT  = 40 * TOTAL_INSNS + RESET_CYCLES;
   localparam logic [31:0] NOP          = 32'h0000_0013;
   // Code sits below this address, data above
   localparam logic [31:0] DATA_BASE    = 32'h0000_0100;
   localparam logic [6:0]  OPC_OP_IMM   = 7'b0010011;
   localparam logic [6:0]  OPC_LOAD     = 7'b0000011;

   logic        clk;
   logic        rst;
   logic        rst_req;
   logic [31:0] wb_adr;
   logic [31:0] wb_dat;
   logic        wb_we;
   logic        wb_cyc;
   logic        wb_stb;
   logic [31:0] wb_rdt;
   logic        wb_ack;

   logic [31:0] mem [256];
   logic [31:0] rd_word;
   logic [31:0] lfsr;
   logic        rand_waits;
   int          wait_left;
   int          cycles;

   logic [31:0] prog_q[$];
   logic [31:0] poke_adr_q[$];
   logic [31:0] poke_dat_q[$];
   logic [31:0] exp_adr_q[$];
   logic [31:0] exp_dat_q[$];
   logic        exp_we_q[$];
   logic [31:0] fetch_log[$];
   logic [31:0] data_adr_log[$];
   logic [31:0] data_dat_log[$];
   logic        data_we_log[$];

   qerv_clk_gen i_clk_gen (
      .i_rst_req (rst_req),
      .o_clk     (clk),
      .o_rst     (rst)
   );

   qerv_core i_qerv_core (
      .clk      (clk),
      .i_rst    (rst),
      .o_wb_adr (wb_adr),
      .o_wb_dat (wb_dat),
      .o_wb_we  (wb_we),
      .o_wb_cyc (wb_cyc),
      .o_wb_stb (wb_stb),
      .i_wb_rdt (wb_rdt),
      .i_wb_ack (wb_ack)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] sign_extend12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (got !== exp) begin
         $display("FAIL %s expected %08h got %08h", name, exp, got);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   // Two LFSR bits give 0 to 3 wait states
   task automatic draw_wait;
      logic [1:0] w;
      int         i;
      for (i = 0; i < 2; i++) begin
         lfsr = lfsr_next(lfsr);
         w[i] = lfsr[0];
      end
      wait_left = rand_waits ? int'(w) : 0;
   endtask

   task automatic fill_memory;
      logic [31:0] a;
      int          i;
      for (i = 0; i < 256; i++) begin
         a      = i * 4;
         mem[i] = (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
      end
   endtask

   task automatic expect_access(input logic [31:0] adr, input logic [31:0] dat,
                                input logic we);
      exp_adr_q.push_back(adr);
      exp_dat_q.push_back(dat);
      exp_we_q.push_back(we);
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the core stopped making progress", cycles);
         $display("** FAIL **");
         $fatal(1, "timeout");
      end
   end

   // Wishbone slave memory with an ack registered and held for one cycle
   always @(posedge clk) begin
      if (rst) begin
         draw_wait();
         #1 wb_ack = 1'b0;
      end else if (wb_ack) begin
         if (wb_adr < DATA_BASE) begin
            fetch_log.push_back(wb_adr);
         end else begin
            data_adr_log.push_back(wb_adr);
            data_dat_log.push_back(wb_dat);
            data_we_log.push_back(wb_we);
            if (wb_we)
               mem[wb_adr[9:2]] = wb_dat;
         end
         draw_wait();
         #1 wb_ack = 1'b0;
      end else if (wb_cyc) begin
         if (wb_adr[31:10] != '0) begin
            $display("Bus address %08h is outside the memory model", wb_adr);
            $display("** FAIL **");
            $fatal(1, "bad address");
         end
         rd_word = mem[wb_adr[9:2]];
         if (wait_left == 0) begin
            #1 wb_rdt = rd_word;
            wb_ack = 1'b1;
         end else begin
            wait_left--;
         end
      end
   end

   task automatic run_program(input string label);
      int i;
      @(posedge clk);
      #1 rst_req = 1'b1;
      wait (rst);
      rst_req = 1'b0;
      fill_memory();
      for (i = 0; i < prog_q.size(); i++)
         mem[i] = prog_q[i];
      for (i = 0; i < 4; i++)
         mem[prog_q.size() + i] = NOP;
      for (i = 0; i < poke_adr_q.size(); i++)
         mem[poke_adr_q[i][9:2]] = poke_dat_q[i];
      fetch_log.delete();
      data_adr_log.delete();
      data_dat_log.delete();
      data_we_log.delete();
      @(posedge clk);
      while (rst) begin
         @(negedge clk);
         if (rst) begin
            check_eq({label, " o_wb_cyc in reset"}, 32'd0, wb_cyc);
            check_eq({label, " o_wb_stb in reset"}, 32'd0, wb_stb);
         end
      end
      @(posedge clk);
      @(negedge clk);
      check_eq({label, " first o_wb_cyc"}, 32'd1, wb_cyc);
      check_eq({label, " first o_wb_stb"}, 32'd1, wb_stb);
      check_eq({label, " first o_wb_adr"}, `QERV_RESET_PC, wb_adr);
      while (data_adr_log.size() < exp_adr_q.size())
         @(negedge clk);
      check_eq({label, " fetch count"}, prog_q.size(), fetch_log.size());
      for (i = 0; i < fetch_log.size(); i++)
         check_eq({label, " fetch o_wb_adr"}, `QERV_RESET_PC + 4 * i, fetch_log[i]);
      for (i = 0; i < exp_adr_q.size(); i++) begin
         check_eq({label, " data o_wb_adr"}, exp_adr_q[i], data_adr_log[i]);
         check_eq({label, " data o_wb_we"}, exp_we_q[i], data_we_log[i]);
         if (exp_we_q[i])
            check_eq({label, " data o_wb_dat"}, exp_dat_q[i], data_dat_log[i]);
      end
      prog_q.delete();
      poke_adr_q.delete();
      poke_dat_q.delete();
      exp_adr_q.delete();
      exp_dat_q.delete();
      exp_we_q.delete();
   endtask

   task automatic test_reset_fetch;
      prog_q.push_back(itype_word(12'h02A, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
      prog_q.push_back(itype_word(12'h001, 5'd1, 3'b000, 5'd2, OPC_OP_IMM));
      prog_q.push_back(stype_word(12'h100, 5'd2, 5'd0));
      expect_access(32'h100, 32'h2A + 32'h1, 1'b1);
      run_program("reset_fetch");
   endtask

   task automatic test_add_sub(input logic waits);
      logic [31:0] x1;
      logic [31:0] x2;
      logic [31:0] x7;
      rand_waits = waits;
      x1 = sign_extend12(12'h7FF);
      x2 = sign_extend12(12'hFFD);
      x7 = 32'h120;
      prog_q.push_back(itype_word(12'h7FF, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
      prog_q.push_back(itype_word(12'hFFD, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
      prog_q.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
      prog_q.push_back(rtype_word(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));
      prog_q.push_back(itype_word(12'h001, 5'd1, 3'b000, 5'd6, OPC_OP_IMM));
      prog_q.push_back(itype_word(12'h120, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
      prog_q.push_back(stype_word(12'h100, 5'd3, 5'd0));
      prog_q.push_back(stype_word(12'h104, 5'd4, 5'd0));
      prog_q.push_back(stype_word(12'h108, 5'd6, 5'd0));
      prog_q.push_back(stype_word(12'h10C, 5'd2, 5'd0));
      prog_q.push_back(stype_word(12'hFF8, 5'd1, 5'd7));
      expect_access(32'h100, x1 + x2, 1'b1);
      expect_access(32'h104, x2 - x1, 1'b1);
      expect_access(32'h108, x1 + 32'd1, 1'b1);
      expect_access(32'h10C, x2, 1'b1);
      expect_access(x7 - 32'd8, x1, 1'b1);
      run_program(waits ? "add_sub_waits" : "add_sub");
      rand_waits = 1'b0;
   endtask

   task automatic test_logic_ops;
      logic [31:0] x1;
      logic [31:0] x2;
      x1 = sign_extend12(12'h5A3);
      x2 = sign_extend12(12'hC94);
      prog_q.push_back(itype_word(12'h5A3, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
      prog_q.push_back(itype_word(12'hC94, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
      prog_q.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd3));
      prog_q.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd4));
      prog_q.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
      prog_q.push_back(stype_word(12'h140, 5'd3, 5'd0));
      prog_q.push_back(stype_word(12'h144, 5'd4, 5'd0));
      prog_q.push_back(stype_word(12'h148, 5'd5, 5'd0));
      expect_access(32'h140, x1 & x2, 1'b1);
      expect_access(32'h144, x1 | x2, 1'b1);
      expect_access(32'h148, x1 ^ x2, 1'b1);
      run_program("logic_ops");
   endtask

   task automatic test_load_store;
      logic [31:0] word;
      word = 32'h9D3C_61E7;
      poke_adr_q.push_back(32'h180);
      poke_dat_q.push_back(word);
      prog_q.push_back(itype_word(12'h170, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
      prog_q.push_back(itype_word(12'h010, 5'd1, 3'b010, 5'd2, OPC_LOAD));
      prog_q.push_back(stype_word(12'h030, 5'd2, 5'd1));
      expect_access(32'h170 + 32'h10, 32'h0, 1'b0);
      expect_access(32'h170 + 32'h30, word, 1'b1);
      run_program("load_store");
   endtask

   task automatic test_x0_write;
      prog_q.push_back(itype_word(12'h123, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
      prog_q.push_back(itype_word(12'h007, 5'd0, 3'b000, 5'd5, OPC_OP_IMM));
      prog_q.push_back(rtype_word(7'h00, 5'd5, 5'd5, 3'b000, 5'd0));
      prog_q.push_back(stype_word(12'h1B0, 5'd0, 5'd0));
      expect_access(32'h1B0, 32'h0, 1'b1);
      run_program("x0_write");
   endtask

   initial begin
      rst_req    = 1'b0;
      wb_ack     = 1'b0;
      wb_rdt     = '0;
      lfsr       = 32'ha46fcbc9;
      rand_waits = 1'b0;
      wait_left  = 0;
      cycles     = 0;
      test_reset_fetch();
      test_add_sub(1'b0);
      test_logic_ops();
      test_load_store();
      test_x0_write();
      test_add_sub(1'b1);
      $display("** PASS **");
      $finish;
   end

endmodule

// File: bench/qerv_core_sva.sv
`timescale 1ns/100ps

module qerv_core_sva import qerv_bus_pkg::*; (
   input logic    clk,
   input logic    i_rst,
   input wb_adr_t o_wb_adr,
   input logic    o_wb_we,
   input logic    o_wb_cyc,
   input logic    o_wb_stb,
   input logic    i_wb_ack
);

   stb_follows_cyc: assert property (@(posedge clk) o_wb_stb == o_wb_cyc)
      else $error("stb differs from cyc");

   // Master holds its request until the ack
   req_held_stable: assert property (@(posedge clk) disable iff (i_rst)
      (o_wb_cyc && !i_wb_ack) |=> ($stable(o_wb_adr) && $stable(o_wb_we)))
      else $error("address or we changed during a pending bus cycle");

   idle_after_reset: assert property (@(posedge clk) $fell(i_rst) |-> !o_wb_cyc)
      else $error("cyc high right after reset");

endmodule

bind qerv_core qerv_core_sva i_qerv_core_sva (
   .clk      (clk),
   .i_rst    (i_rst),
   .o_wb_adr (o_wb_adr),
   .o_wb_we  (o_wb_we),
   .o_wb_cyc (o_wb_cyc),
   .o_wb_stb (o_wb_stb),
   .i_wb_ack (i_wb_ack)
);

// File: bench/qerv_clk_gen.sv
`timescale 1ns/100ps

module qerv_clk_gen (
   input  logic i_rst_req,
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #2 o_clk = ~o_clk;
   end

   // Reset for 10 cycles at start and again on each request
   initial begin
      o_rst = 1'b1;
      forever begin
         repeat (10) @(posedge o_clk);
         #1 o_rst = 1'b0;
         wait (i_rst_req);
         @(posedge o_clk);
         #1 o_rst = 1'b1;
      end
   end

endmodule

// File: logic/qerv_core.sv
`timescale 1ns/100ps

`include "qerv_defines.svh"

module qerv_core import qerv_isa_pkg::*, qerv_bus_pkg::*; (
   input  logic    clk,
   input  logic    i_rst,
   output wb_adr_t o_wb_adr,
   output wb_dat_t o_wb_dat,
   output logic    o_wb_we,
   output logic    o_wb_cyc,
   output logic    o_wb_stb,
   input  wb_dat_t i_wb_rdt,
   input  logic    i_wb_ack
);

   core_state_e state;
   wb_adr_t     pc;
   logic        fetch_req;
   logic        fetch_ack;
   logic        nib_en;
   nib_cnt_t    nib_cnt;
   logic        cnt_done;
   logic        rd_wen;
   logic        mem_start;
   logic        mem_done;
   reg_addr_t   rs1;
   reg_addr_t   rs2;
   reg_addr_t   rd;
   nibble_t     imm;
   alu_op_e     alu_op;
   logic        use_imm;
   logic        is_load;
   logic        is_store;
   logic        wr_rd;
   nibble_t     rs1_nib;
   nibble_t     rs2_nib;
   nibble_t     op_b;
   nibble_t     alu_res;
   nibble_t     load_nib;
   nibble_t     rd_nib;
   logic        insn_end;
   wb_adr_t     l_adr;
   wb_dat_t     l_dat;
   logic        l_we;
   logic        l_cyc;
   logic        l_stb;
   logic        l_ack;

   assign op_b   = use_imm ? imm : rs2_nib;
   assign rd_nib = is_load ? load_nib : alu_res;

   // Last cycle of EXEC, MEM for a store, or WBACK
   assign insn_end = (cnt_done & (state == ST_WBACK)) |
                     (cnt_done & (state == ST_EXEC) & ~is_load & ~is_store) |
                     (mem_done & is_store);

   always_ff @(posedge clk) begin
      if (i_rst)
         pc <= `QERV_RESET_PC;
      else if (insn_end)
         pc <= pc + 32'd4;
   end

   qerv_state i_state (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_fetch_ack (fetch_ack),
      .i_is_load   (is_load),
      .i_is_store  (is_store),
      .i_mem_done  (mem_done),
      .o_state     (state),
      .o_fetch_req (fetch_req),
      .o_nib_en    (nib_en),
      .o_nib_cnt   (nib_cnt),
      .o_cnt_done  (cnt_done),
      .o_rd_wen    (rd_wen),
      .o_mem_start (mem_start)
   );

   qerv_decode i_decode (
      .clk         (clk),
      .i_fetch_ack (fetch_ack),
      .i_insn      (i_wb_rdt),
      .i_nib_cnt   (nib_cnt),
      .o_rs1       (rs1),
      .o_rs2       (rs2),
      .o_rd        (rd),
      .o_imm       (imm),
      .o_alu_op    (alu_op),
      .o_use_imm   (use_imm),
      .o_is_load   (is_load),
      .o_is_store  (is_store),
      .o_wr_rd     (wr_rd)
   );

   qerv_rf i_rf (
      .clk       (clk),
      .i_nib_cnt (nib_cnt),
      .i_rs1     (rs1),
      .i_rs2     (rs2),
      .i_rd      (rd),
      .i_wen     (rd_wen & wr_rd),
      .i_wdata   (rd_nib),
      .o_rs1_nib (rs1_nib),
      .o_rs2_nib (rs2_nib)
   );

   qerv_alu i_alu (
      .clk      (clk),
      .i_nib_en (nib_en),
      .i_first  (nib_cnt == '0),
      .i_op     (alu_op),
      .i_a      (rs1_nib),
      .i_b      (op_b),
      .o_res    (alu_res)
   );

   qerv_mem_if i_mem_if (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_nib_en   (nib_en),
      .i_nib_cnt  (nib_cnt),
      .i_addr_nib (alu_res),
      .i_data_nib (rs2_nib),
      .i_start    (mem_start),
      .i_we       (is_store),
      .i_ack      (l_ack),
      .i_rdt      (i_wb_rdt),
      .o_adr      (l_adr),
      .o_dat      (l_dat),
      .o_we       (l_we),
      .o_cyc      (l_cyc),
      .o_stb      (l_stb),
      .o_done     (mem_done),
      .o_load_nib (load_nib)
   );

   // Internal stb always equals cyc, so only cyc is arbitrated
   qerv_bus_arbiter i_bus_arbiter (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_f_adr  (pc),
      .i_f_cyc  (fetch_req),
      .i_l_adr  (l_adr),
      .i_l_dat  (l_dat),
      .i_l_we   (l_we),
      .i_l_cyc  (l_cyc & l_stb),
      .i_wb_ack (i_wb_ack),
      .o_f_ack  (fetch_ack),
      .o_l_ack  (l_ack),
      .o_wb_adr (o_wb_adr),
      .o_wb_dat (o_wb_dat),
      .o_wb_we  (o_wb_we),
      .o_wb_cyc (o_wb_cyc),
      .o_wb_stb (o_wb_stb)
   );

endmodule

// File: logic/qerv_bus_arbiter.sv
`timescale 1ns/100ps

module qerv_bus_arbiter import qerv_bus_pkg::*; (
   input  logic    clk,
   input  logic    i_rst,
   input  wb_adr_t i_f_adr,
   input  logic    i_f_cyc,
   input  wb_adr_t i_l_adr,
   input  wb_dat_t i_l_dat,
   input  logic    i_l_we,
   input  logic    i_l_cyc,
   input  logic    i_wb_ack,
   output logic    o_f_ack,
   output logic    o_l_ack,
   output wb_adr_t o_wb_adr,
   output wb_dat_t o_wb_dat,
   output logic    o_wb_we,
   output logic    o_wb_cyc,
   output logic    o_wb_stb
);

   master_e grant;
   master_e sel;
   logic    locked;

   // Idle bus follows the requests directly, fetch first
   always_comb begin
      if (locked)
         sel = grant;
      else if (i_f_cyc)
         sel = M_FETCH;
      else if (i_l_cyc)
         sel = M_LSU;
      else
         sel = grant;
   end

   assign o_wb_cyc = (sel == M_FETCH) ? i_f_cyc : i_l_cyc;
   assign o_wb_stb = o_wb_cyc;
   assign o_wb_adr = (sel == M_FETCH) ? i_f_adr : i_l_adr;
   assign o_wb_dat = (sel == M_LSU) ? i_l_dat : '0;
   assign o_wb_we  = (sel == M_LSU) & i_l_we;
   assign o_f_ack  = (sel == M_FETCH) & i_wb_ack;
   assign o_l_ack  = (sel == M_LSU) & i_wb_ack;

   // Held until the ack that ends the cycle
   always_ff @(posedge clk) begin
      if (i_rst) begin
         locked <= 1'b0;
         grant  <= M_FETCH;
      end else begin
         locked <= o_wb_cyc & ~i_wb_ack;
         if (!locked)
            grant <= sel;
      end
   end

endmodule

// File: logic/qerv_mem_if.sv
`timescale 1ns/100ps

`include "qerv_defines.svh"

module qerv_mem_if import qerv_isa_pkg::*, qerv_bus_pkg::*; (
   input  logic     clk,
   input  logic     i_rst,
   input  logic     i_nib_en,
   input  nib_cnt_t i_nib_cnt,
   input  nibble_t  i_addr_nib,
   input  nibble_t  i_data_nib,
   input  logic     i_start,
   input  logic     i_we,
   input  logic     i_ack,
   input  wb_dat_t  i_rdt,
   output wb_adr_t  o_adr,
   output wb_dat_t  o_dat,
   output logic     o_we,
   output logic     o_cyc,
   output logic     o_stb,
   output logic     o_done,
   output nibble_t  o_load_nib
);

   wb_dat_t rdata;

   // Address and store data arrive LSB first during EXEC
   always_ff @(posedge clk) begin
      if (i_nib_en) begin
         o_adr <= {i_addr_nib, o_adr[`QERV_XLEN-1:`QERV_W]};
         o_dat <= {i_data_nib, o_dat[`QERV_XLEN-1:`QERV_W]};
      end
      if (i_start)
         o_we <= i_we;
      if (o_done && !o_we)
         rdata <= i_rdt;
   end

   always_ff @(posedge clk) begin
      if (i_rst)
         o_cyc <= 1'b0;
      else if (i_start)
         o_cyc <= 1'b1;
      else if (i_ack)
         o_cyc <= 1'b0;
   end

   assign o_stb      = o_cyc;
   assign o_done     = o_cyc & i_ack;
   // Replayed one nibble per WBACK cycle
   assign o_load_nib = rdata[i_nib_cnt*`QERV_W +: `QERV_W];

endmodule

// File: logic/qerv_alu.sv
`timescale 1ns/100ps

`include "qerv_defines.svh"

module qerv_alu import qerv_isa_pkg::*; (
   input  logic    clk,
   input  logic    i_nib_en,
   input  logic    i_first,
   input  alu_op_e i_op,
   input  nibble_t i_a,
   input  nibble_t i_b,
   output nibble_t o_res
);

   logic            carry_q;
   logic            cin;
   nibble_t         b_eff;
   logic [`QERV_W:0] sum;

   // Subtract as a + ~b + 1
   assign b_eff = (i_op == ALU_SUB) ? ~i_b : i_b;
   assign cin   = i_first ? (i_op == ALU_SUB) : carry_q;
   assign sum   = {1'b0, i_a} + {1'b0, b_eff} + {{`QERV_W{1'b0}}, cin};

   always_ff @(posedge clk) begin
      if (i_nib_en)
         carry_q <= sum[`QERV_W];
   end

   always_comb begin
      case (i_op)
         ALU_AND: o_res = i_a & i_b;
         ALU_OR:  o_res = i_a | i_b;
         ALU_XOR: o_res = i_a ^ i_b;
         default: o_res = sum[`QERV_W-1:0];
      endcase
   end

endmodule

// File: logic/qerv_rf.sv
`timescale 1ns/100ps

`include "qerv_defines.svh"

module qerv_rf import qerv_isa_pkg::*; (
   input  logic      clk,
   input  nib_cnt_t  i_nib_cnt,
   input  reg_addr_t i_rs1,
   input  reg_addr_t i_rs2,
   input  reg_addr_t i_rd,
   input  logic      i_wen,
   input  nibble_t   i_wdata,
   output nibble_t   o_rs1_nib,
   output nibble_t   o_rs2_nib
);

   word_t regs [32];

   // x0 is never written, so it reads as a constant
   assign o_rs1_nib = (i_rs1 == '0) ? '0 :
                      regs[i_rs1][i_nib_cnt*`QERV_W +: `QERV_W];
   assign o_rs2_nib = (i_rs2 == '0) ? '0 :
                      regs[i_rs2][i_nib_cnt*`QERV_W +: `QERV_W];

   // Nibble n of rd lands after nibble n of the sources was read
   always_ff @(posedge clk) begin
      if (i_wen && (i_rd != '0))
         regs[i_rd][i_nib_cnt*`QERV_W +: `QERV_W] <= i_wdata;
   end

endmodule

// File: logic/qerv_decode.sv
`timescale 1ns/100ps

`include "qerv_defines.svh"

module qerv_decode import qerv_isa_pkg::*, qerv_bus_pkg::*; (
   input  logic      clk,
   input  logic      i_fetch_ack,
   input  wb_dat_t   i_insn,
   input  nib_cnt_t  i_nib_cnt,
   output reg_addr_t o_rs1,
   output reg_addr_t o_rs2,
   output reg_addr_t o_rd,
   output nibble_t   o_imm,
   output alu_op_e   o_alu_op,
   output logic      o_use_imm,
   output logic      o_is_load,
   output logic      o_is_store,
   output logic      o_wr_rd
);

   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;

   word_t      ir;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       is_addi;
   logic       op_valid;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_w;

   always_ff @(posedge clk) begin
      if (i_fetch_ack)
         ir <= i_insn;
   end

   assign opcode = ir[6:0];
   assign funct3 = ir[14:12];
   assign funct7 = ir[31:25];
   assign o_rd   = ir[11:7];
   assign o_rs1  = ir[19:15];
   assign o_rs2  = ir[24:20];

   assign is_addi    = (opcode == OPC_OP_IMM) & (funct3 == 3'b000);
   assign o_is_load  = (opcode == OPC_LOAD) & (funct3 == 3'b010);
   assign o_is_store = (opcode == OPC_STORE) & (funct3 == 3'b010);
   assign o_use_imm  = is_addi | o_is_load | o_is_store;
   assign o_wr_rd    = is_addi | op_valid | o_is_load;

   // Register ops, everything else adds
   always_comb begin
      o_alu_op = ALU_ADD;
      op_valid = 1'b0;
      if (opcode == OPC_OP) begin
         case (funct3)
            3'b000: begin
               o_alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
               op_valid = (funct7 == 7'h00) | (funct7 == 7'h20);
            end
            3'b100: begin
               o_alu_op = ALU_XOR;
               op_valid = (funct7 == 7'h00);
            end
            3'b110: begin
               o_alu_op = ALU_OR;
               op_valid = (funct7 == 7'h00);
            end
            3'b111: begin
               o_alu_op = ALU_AND;
               op_valid = (funct7 == 7'h00);
            end
            default: op_valid = 1'b0;
         endcase
      end
   end

   // Sign bit fills nibbles 3 to 7
   assign imm_i = {{20{ir[31]}}, ir[31:20]};
   assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
   assign imm_w = o_is_store ? imm_s : imm_i;
   assign o_imm = imm_w[i_nib_cnt*`QERV_W +: `QERV_W];

endmodule

// File: logic/qerv_state.sv
`timescale 1ns/100ps

`include "qerv_defines.svh"

module qerv_state import qerv_isa_pkg::*; (
   input  logic        clk,
   input  logic        i_rst,
   input  logic        i_fetch_ack,
   input  logic        i_is_load,
   input  logic        i_is_store,
   input  logic        i_mem_done,
   output core_state_e o_state,
   output logic        o_fetch_req,
   output logic        o_nib_en,
   output nib_cnt_t    o_nib_cnt,
   output logic        o_cnt_done,
   output logic        o_rd_wen,
   output logic        o_mem_start
);

   core_state_e state;
   core_state_e state_n;
   nib_cnt_t    cnt;
   logic        mem_op;

   assign mem_op      = i_is_load | i_is_store;
   assign o_nib_en    = (state == ST_EXEC) | (state == ST_WBACK);
   assign o_cnt_done  = o_nib_en & (cnt == nib_cnt_t'(`QERV_NIBBLES - 1));
   assign o_mem_start = (state == ST_EXEC) & o_cnt_done & mem_op;
   // ALU results go to rd in EXEC, load data in WBACK
   assign o_rd_wen    = ((state == ST_EXEC) & ~mem_op) | (state == ST_WBACK);
   assign o_nib_cnt   = cnt;
   assign o_state     = state;

   always_comb begin
      state_n = state;
      case (state)
         ST_FETCH: if (i_fetch_ack) state_n = ST_EXEC;
         ST_EXEC:  if (o_cnt_done) state_n = mem_op ? ST_MEM : ST_FETCH;
         ST_MEM:   if (i_mem_done) state_n = i_is_load ? ST_WBACK : ST_FETCH;
         ST_WBACK: if (o_cnt_done) state_n = ST_FETCH;
         default:  state_n = ST_FETCH;
      endcase
   end

   // Fetch request is registered so the bus stays quiet during reset
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state       <= ST_FETCH;
         cnt         <= '0;
         o_fetch_req <= 1'b0;
      end else begin
         state       <= state_n;
         o_fetch_req <= (state_n == ST_FETCH);
         if (o_nib_en)
            cnt <= cnt + 1'b1;
      end
   end

endmodule

// File: logic/qerv_bus_pkg.sv
package qerv_bus_pkg;

`include "qerv_defines.svh"

   typedef logic [`QERV_XLEN-1:0] wb_adr_t;
   typedef logic [`QERV_XLEN-1:0] wb_dat_t;

   // Masters sharing the Wishbone bus
   typedef enum logic {
      M_FETCH,
      M_LSU
   } master_e;

endpackage

// File: logic/qerv_isa_pkg.sv
package qerv_isa_pkg;

`include "qerv_defines.svh"

   typedef logic [`QERV_W-1:0]    nibble_t;
   typedef logic [`QERV_XLEN-1:0] word_t;
   typedef logic [4:0]            reg_addr_t;
   typedef logic [2:0]            nib_cnt_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   // One instruction in flight, these are its phases
   typedef enum logic [1:0] {
      ST_FETCH,
      ST_EXEC,
      ST_MEM,
      ST_WBACK
   } core_state_e;

endpackage

// File: logic/qerv_defines.svh
`ifndef QERV_DEFINES_SVH
`define QERV_DEFINES_SVH

// Bits handled per clock
`define QERV_W 4

`define QERV_XLEN 32

// Serial slices per word
`define QERV_NIBBLES 8

// First fetch address
`define QERV_RESET_PC 32'h0000_0000

`endif
